//--- design/aes_pkg.sv
package aes_pkg;

    // Geometry of one AES state.
    localparam int state_bytes = 16;                  // Bytes in a 4x4 state.
    localparam int byte_idx_w  = 4;                   // Enough to address 16 bytes.

    // Field and S-box constants.
    localparam logic [7:0] gf_poly      = 8'h1b;      // x^8 + x^4 + x^3 + x + 1, low byte.
    localparam logic [7:0] sbox_affine_c = 8'h63;     // Constant added by the affine step.

    // Collector fill state.
    typedef enum logic
    {
        filling = 1'b0,                               // Taking substituted bytes.
        full    = 1'b1                                // Holding a finished state.
    } collect_state_t;

    // Multiply two bytes in GF(2^8) modulo the AES polynomial.
    // Shift-and-add, reducing the running multiple whenever bit 7 falls out.
    function automatic logic [7:0] gf_mul
    (
        input logic [7:0] a,
        input logic [7:0] b
    );
        logic [7:0] acc;
        logic [7:0] mult;
        int         bit_i;

        acc  = '0;
        mult = a;
        for (bit_i = 0; bit_i < 8; bit_i++)
        begin
            if (b[bit_i])
            begin
                acc = acc ^ mult;                     // Add this power of a.
            end
            if (mult[7])
            begin
                mult = {mult[6:0], 1'b0} ^ gf_poly;   // Reduce after the shift.
            end
            else
            begin
                mult = {mult[6:0], 1'b0};
            end
        end
        return acc;
    endfunction

endpackage

//--- design/add_round_key.sv
module add_round_key
(
    input  logic                                  clk,
    input  logic                                  resetn,

    // Incoming block and its round key.
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [aes_pkg::state_bytes-1:0][7:0]  in_state,
    input  logic [aes_pkg::state_bytes-1:0][7:0]  in_key,

    // Sum towards the state register.
    output logic                                  ark_valid,
    input  logic                                  ark_ready,
    output logic [aes_pkg::state_bytes-1:0][7:0]  ark_state
);

    import aes_pkg::*;

    logic                              take_in;       // Input accepted this cycle.
    logic                              give_out;      // Sum taken this cycle.
    logic [state_bytes-1:0][7:0]       sum_next;

    // The slot is free if empty or drained on this very edge.
    assign in_ready = !ark_valid || ark_ready;
    assign take_in  = in_valid && in_ready;
    assign give_out = ark_valid && ark_ready;

    // AddRoundKey is a plain bytewise XOR.
    assign sum_next = in_state ^ in_key;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ark_valid <= 1'b0;
        end
        else if (take_in)
        begin
            ark_valid <= 1'b1;                        // New sum replaces any outgoing one.
        end
        else if (give_out)
        begin
            ark_valid <= 1'b0;
        end
    end

    // Payload only changes on accept.
    always_ff @(posedge clk)
    begin
        if (take_in)
        begin
            ark_state <= sum_next;
        end
    end

endmodule

//--- design/state_reg16.sv
module state_reg16
(
    input  logic                                  clk,
    input  logic                                  resetn,

    // Parallel load from AddRoundKey.
    input  logic                                  ark_valid,
    output logic                                  ark_ready,
    input  logic [aes_pkg::state_bytes-1:0][7:0]  ark_state,

    // Byte stream towards the S-box.
    output logic                                  rd_valid,
    input  logic                                  rd_ready,
    output logic [7:0]                            rd_byte,
    output logic [aes_pkg::byte_idx_w-1:0]        rd_idx
);

    import aes_pkg::*;

    localparam logic [byte_idx_w-1:0] last_idx = byte_idx_w'(state_bytes - 1);

    logic [state_bytes-1:0][7:0]  state_q;            // The 16 loaded bytes.
    logic [byte_idx_w-1:0]        rd_cnt;             // Next byte to hand out.
    logic                         reg_empty;          // 1 once every byte has left.
    logic                         load;
    logic                         rd_fire;

    // Loading is only allowed once the previous block is fully read.
    assign ark_ready = reg_empty;
    assign load      = ark_valid && reg_empty;

    assign rd_valid  = !reg_empty;
    assign rd_fire   = rd_valid && rd_ready;

    assign rd_byte   = state_q[rd_cnt];               // Counter picks the byte.
    assign rd_idx    = rd_cnt;

    // Empty flag and read counter.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            reg_empty <= 1'b1;
            rd_cnt    <= '0;
        end
        else if (load)
        begin
            reg_empty <= 1'b0;
            rd_cnt    <= '0;                          // Restart at byte 0.
        end
        else if (rd_fire)
        begin
            if (rd_cnt == last_idx)
            begin
                reg_empty <= 1'b1;                    // Byte 15 gone.
                rd_cnt    <= '0;
            end
            else
            begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // Byte storage, written in one go.
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            state_q <= ark_state;
        end
    end

endmodule

//--- design/sbox_unit.sv
module sbox_unit
#(
    parameter bit inv_reg = 1'b1                      // Register between inverse and affine.
)
(
    input  logic                                  clk,
    input  logic                                  resetn,

    // Byte stream from the state register.
    input  logic                                  rd_valid,
    output logic                                  rd_ready,
    input  logic [7:0]                            rd_byte,
    input  logic [aes_pkg::byte_idx_w-1:0]        rd_idx,

    // Substituted byte stream.
    output logic                                  sb_valid,
    input  logic                                  sb_ready,
    output logic [7:0]                            sb_byte,
    output logic [aes_pkg::byte_idx_w-1:0]        sb_idx
);

    import aes_pkg::*;

    // x^254 as the product of x^2, x^4, ... x^128.
    // Zero stays zero, which is what the S-box wants.
    function automatic logic [7:0] gf_inv(input logic [7:0] x);
        logic [7:0] sq;
        logic [7:0] prod;
        int         k;

        sq   = x;
        prod = 8'h01;
        for (k = 1; k < 8; k++)
        begin
            sq   = gf_mul(sq, sq);
            prod = gf_mul(prod, sq);
        end
        return prod;
    endfunction

    // b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63h.
    function automatic logic [7:0] affine(input logic [7:0] b);
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                 ^ {b[3:0], b[7:4]} ^ sbox_affine_c;
    endfunction

    logic                   mid_valid;                // Inverse stage towards output.
    logic                   mid_ready;
    logic [7:0]             mid_byte;
    logic [byte_idx_w-1:0]  mid_idx;

    // The output stage moves when it is empty or drained.
    assign mid_ready = !sb_valid || sb_ready;

    generate
        if (inv_reg)
        begin : g_inv_reg
            always_ff @(posedge clk or negedge resetn)
            begin
                if (!resetn)
                begin
                    mid_valid <= 1'b0;
                end
                else if (rd_ready)
                begin
                    mid_valid <= rd_valid;
                end
            end

            always_ff @(posedge clk)
            begin
                if (rd_ready && rd_valid)
                begin
                    mid_byte <= gf_inv(rd_byte);
                    mid_idx  <= rd_idx;
                end
            end

            assign rd_ready = !mid_valid || mid_ready;    // Stall only when both stages hold.
        end
        else
        begin : g_no_inv_reg
            assign mid_valid = rd_valid;
            assign mid_byte  = gf_inv(rd_byte);
            assign mid_idx   = rd_idx;
            assign rd_ready  = mid_ready;
        end
    endgenerate

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            sb_valid <= 1'b0;
        end
        else if (mid_ready)
        begin
            sb_valid <= mid_valid;
        end
    end

    // Index rides along with its byte.
    always_ff @(posedge clk)
    begin
        if (mid_ready && mid_valid)
        begin
            sb_byte <= affine(mid_byte);
            sb_idx  <= mid_idx;
        end
    end

endmodule

//--- design/shift_rows_collect.sv
module shift_rows_collect
(
    input  logic                                  clk,
    input  logic                                  resetn,

    // Substituted bytes with their source index.
    input  logic                                  sb_valid,
    output logic                                  sb_ready,
    input  logic [7:0]                            sb_byte,
    input  logic [aes_pkg::byte_idx_w-1:0]        sb_idx,

    // Finished state after ShiftRows.
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [aes_pkg::state_bytes-1:0][7:0]  out_state
);

    import aes_pkg::*;

    localparam logic [byte_idx_w-1:0] last_cnt = byte_idx_w'(state_bytes - 1);

    collect_state_t         fill_state;
    logic [byte_idx_w-1:0]  byte_cnt;                 // Bytes written so far.
    logic [1:0]             src_row;
    logic [1:0]             src_col;
    logic [1:0]             dst_col;
    logic [byte_idx_w-1:0]  dst_idx;
    logic                   wr_fire;

    // Column-major numbering: low bits are the row.
    assign src_row = sb_idx[1:0];
    assign src_col = sb_idx[3:2];
    assign dst_col = src_col - src_row;               // Wraps mod 4.
    assign dst_idx = {dst_col, src_row};

    assign sb_ready  = (fill_state == filling);
    assign out_valid = (fill_state == full);
    assign wr_fire   = sb_valid && sb_ready;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            fill_state <= filling;
            byte_cnt   <= '0;
        end
        else
        begin
            case (fill_state)
                filling:
                begin
                    if (wr_fire)
                    begin
                        if (byte_cnt == last_cnt)
                        begin
                            fill_state <= full;        // Sixteenth byte in.
                            byte_cnt   <= '0;
                        end
                        else
                        begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                full:
                begin
                    if (out_ready)
                    begin
                        fill_state <= filling;
                    end
                end
                default:
                begin
                    fill_state <= filling;
                end
            endcase
        end
    end

    // Held untouched while full.
    always_ff @(posedge clk)
    begin
        if (wr_fire)
        begin
            out_state[dst_idx] <= sb_byte;
        end
    end

endmodule

//--- design/aes_sub_shift_top.sv
module aes_sub_shift_top
#(
    parameter bit inv_reg = 1'b1                      // Extra S-box pipeline stage.
)
(
    input  logic                                  clk,
    input  logic                                  resetn,

    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [aes_pkg::state_bytes-1:0][7:0]  in_state,
    input  logic [aes_pkg::state_bytes-1:0][7:0]  in_key,

    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [aes_pkg::state_bytes-1:0][7:0]  out_state
);

    import aes_pkg::*;

    // AddRoundKey to state register.
    logic                          ark_valid;
    logic                          ark_ready;
    logic [state_bytes-1:0][7:0]   ark_state;

    // State register to S-box.
    logic                          rd_valid;
    logic                          rd_ready;
    logic [7:0]                    rd_byte;
    logic [byte_idx_w-1:0]         rd_idx;

    // S-box to collector.
    logic                          sb_valid;
    logic                          sb_ready;
    logic [7:0]                    sb_byte;
    logic [byte_idx_w-1:0]         sb_idx;

    add_round_key ark_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_state  (in_state),
        .in_key    (in_key),
        .ark_valid (ark_valid),
        .ark_ready (ark_ready),
        .ark_state (ark_state)
    );

    state_reg16 sreg_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .ark_valid (ark_valid),
        .ark_ready (ark_ready),
        .ark_state (ark_state),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_byte   (rd_byte),
        .rd_idx    (rd_idx)
    );

    sbox_unit #(.inv_reg(inv_reg)) sbox_i
    (
        .clk      (clk),
        .resetn   (resetn),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rd_byte  (rd_byte),
        .rd_idx   (rd_idx),
        .sb_valid (sb_valid),
        .sb_ready (sb_ready),
        .sb_byte  (sb_byte),
        .sb_idx   (sb_idx)
    );

    shift_rows_collect collect_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .sb_valid  (sb_valid),
        .sb_ready  (sb_ready),
        .sb_byte   (sb_byte),
        .sb_idx    (sb_idx),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_state (out_state)
    );

endmodule

//--- verification/aes_tb_model.sv
package aes_tb_model;

    typedef logic [15:0][7:0] block_t;                // Byte 0 in the low bits.

    localparam logic [31:0] lfsr_seed = 32'h3905_a96a;

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // Horner form, top bit of b first.
    function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        int         i;

        p = 8'h00;
        for (i = 7; i >= 0; i--)
        begin
            p = xtime(p);
            if (b[i])
            begin
                p = p ^ a;
            end
        end
        return p;
    endfunction

    // Exhaustive search for the partner whose product is one.
    function automatic logic [7:0] field_inv(input logic [7:0] x);
        int y;

        for (y = 1; y < 256; y++)
        begin
            if (field_mul(x, y[7:0]) == 8'h01)
            begin
                return y[7:0];
            end
        end
        return 8'h00;                                 // Zero has no inverse.
    endfunction

    function automatic logic [7:0] sbox_ref(input logic [7:0] b);
        logic [7:0] v;
        logic [7:0] s;
        int         i;

        v = field_inv(b);
        for (i = 0; i < 8; i++)
        begin
            s[i] = v[i] ^ v[(i + 4) % 8] ^ v[(i + 5) % 8] ^ v[(i + 6) % 8]
                 ^ v[(i + 7) % 8] ^ (8'h63 >> i);
        end
        return s;
    endfunction

    // Output (row, col) takes input (row, col + row).
    function automatic block_t shift_rows_ref(input block_t b);
        block_t o;
        int     r;
        int     c;

        for (c = 0; c < 4; c++)
        begin
            for (r = 0; r < 4; r++)
            begin
                o[c * 4 + r] = b[((c + r) % 4) * 4 + r];
            end
        end
        return o;
    endfunction

    function automatic block_t expected_block(input block_t s, input block_t k);
        block_t sub;
        int     i;

        for (i = 0; i < 16; i++)
        begin
            sub[i] = sbox_ref(s[i] ^ k[i]);
        end
        return shift_rows_ref(sub);
    endfunction

endpackage

//--- verification/tb_aes_sub_shift.sv
module tb_aes_sub_shift;

    timeunit 1ns;
    timeprecision 1ps;

    import aes_tb_model::*;

    localparam int send_limit  = 2000;                // Cycles to wait for in_ready.
    localparam int drain_limit = 20000;               // Cycles to wait for all results.

    logic        clk;
    logic        resetn;
    logic        in_valid;
    logic        in_ready;
    block_t      in_state;
    block_t      in_key;
    logic        out_valid;
    logic        out_ready;
    block_t      out_state;

    logic [31:0] lfsr;
    block_t      tx_state_q[$];
    block_t      tx_key_q[$];
    int          tx_gap_q[$];
    block_t      exp_q[$];                            // Results still to come out.
    block_t      held_state;
    bit          hold_valid = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_base = 0;

    aes_sub_shift_top #(.inv_reg(1'b1)) dut_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_state  (in_state),
        .in_key    (in_key),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_state (out_state)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s: expected %0h, got %0h", name, expected, actual);
        end
    endtask

    task automatic compare_state(input block_t actual, input block_t expected);
        int b;

        for (b = 0; b < 16; b++)
        begin
            check_value($sformatf("out_state[%0d]", b), actual[b], expected[b]);
        end
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;

        r = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);                   // One step per bit.
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic block_t rand_block();
        block_t b;
        int     w;

        for (w = 0; w < 4; w++)
        begin
            b[w * 4 +: 4] = rand_bits(32);
        end
        return b;
    endfunction

    task automatic queue_block(input block_t s, input block_t k, input int gap,
                               input block_t expected);
        tx_state_q.push_back(s);
        tx_key_q.push_back(k);
        tx_gap_q.push_back(gap);
        exp_q.push_back(expected);
    endtask

    task automatic queue_random(input int n, input bit use_gaps);
        block_t s;
        block_t k;
        int     gap;
        int     i;

        for (i = 0; i < n; i++)
        begin
            s   = rand_block();
            k   = rand_block();
            gap = use_gaps ? int'(rand_bits(2)) : 0;
            queue_block(s, k, gap, expected_block(s, k));
        end
    endtask

    // Called just after a rising edge.
    task automatic send_all();
        block_t s;
        block_t k;
        int     gap;
        int     wait_cnt;
        bit     taken;

        while (tx_state_q.size() != 0)
        begin
            s   = tx_state_q.pop_front();
            k   = tx_key_q.pop_front();
            gap = tx_gap_q.pop_front();
            if (gap > 0)
            begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            in_valid <= 1'b1;
            in_state <= s;
            in_key   <= k;
            taken    = 1'b0;
            wait_cnt = 0;
            while (!taken && wait_cnt < send_limit)
            begin
                @(negedge clk);
                taken = in_ready;                     // Transfer on the coming edge.
                @(posedge clk);
                wait_cnt++;
            end
            if (!taken)
            begin
                errors++;
                $display("Timeout: in_ready stayed low and a block was not accepted");
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic drive_ready(input bit use_bp);
        logic [31:0] r;
        int          cycles;

        cycles = 0;
        while (exp_q.size() != 0 && cycles < drain_limit)
        begin
            r = use_bp ? rand_bits(1) : 32'h1;
            out_ready <= r[0];
            @(posedge clk);
            cycles++;
        end
        out_ready <= 1'b1;
    endtask

    task automatic run_traffic(input bit use_bp);
        @(posedge clk);
        fork
            send_all();
            drive_ready(use_bp);
        join
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("Timeout: %0d blocks never came out of the DUT", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_err_base)
        begin
            tests_failed++;
            $display("Test %s: FAILED with %0d errors", name, errors - test_err_base);
        end
        else
        begin
            $display("Test %s: ok", name);
        end
        test_err_base = errors;
    endtask

    // Output monitor, sampled mid-cycle.
    always @(negedge clk)
    begin
        if (resetn && out_valid)
        begin
            if (hold_valid)
            begin
                compare_state(out_state, held_state); // Stalled result must not move.
            end
            if (out_ready)
            begin
                hold_valid = 1'b0;
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("Unexpected output block with nothing queued");
                end
                else
                begin
                    compare_state(out_state, exp_q.pop_front());
                end
            end
            else
            begin
                held_state = out_state;
                hold_valid = 1'b1;
            end
        end
    end

    initial
    begin
        block_t s;
        block_t k;
        int     i;

        resetn    = 1'b0;
        in_valid  = 1'b0;
        in_state  = '0;
        in_key    = '0;
        out_ready = 1'b0;
        lfsr      = lfsr_seed;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;

        @(negedge clk);
        check_value("out_valid", out_valid, 32'h0);
        check_value("in_ready", in_ready, 32'h1);
        finish_test("reset_values");

        for (i = 0; i < 16; i++)
        begin
            s[i] = 8'(i * 17);                        // 00 11 22 ... ff.
            k[i] = 8'(i);
        end
        queue_block(s, k, 0, expected_block(s, k));
        run_traffic(1'b0);
        finish_test("known_vector");

        queue_random(20, 1'b0);
        run_traffic(1'b0);
        finish_test("back_to_back");

        queue_random(20, 1'b0);
        run_traffic(1'b1);
        finish_test("back_pressure");

        queue_random(20, 1'b1);
        run_traffic(1'b0);
        finish_test("input_gaps");

        s = rand_block();
        queue_block(s, s, 0, {16{8'h63}});            // Sum is all zero.
        s = rand_block();
        queue_block(s, ~s, 0, {16{8'h16}});           // Sum is all ff.
        run_traffic(1'b0);
        finish_test("edge_bytes");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- list.f
design/aes_pkg.sv
design/add_round_key.sv
design/state_reg16.sv
design/sbox_unit.sv
design/shift_rows_collect.sv
design/aes_sub_shift_top.sv
verification/aes_tb_model.sv
verification/tb_aes_sub_shift.sv
